//--- source/dcache_pkg.sv
// Cache geometry constants with the load/store, memory bus and cache line types
package dcache_pkg;

	// Direct-mapped, 16 lines of 64 bytes
	localparam int BEATS_PER_LINE = 8;
	localparam int LINE_COUNT = 16;
	localparam int OFFSET_BITS = 6;
	localparam int INDEX_BITS = 4;
	localparam int TAG_BITS = 22;

	// Load/store unit request, rw is 1 for read
	typedef struct packed {
		logic rw;
		logic [3:0] mask;
		logic [31:0] addr;
		logic [31:0] wdata;
	} ldst_req_t;

	// Response back to the load/store unit
	typedef struct packed {
		logic valid;
		logic pagefault;
		logic [31:0] data;
	} ldst_rsp_t;

	// Memory bus request, held until mem_lock drops
	typedef struct packed {
		logic req;
		logic rw;
		logic [3:0] mask;
		logic [31:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	// One beat or write acknowledge from memory
	typedef struct packed {
		logic valid;
		logic pagefault;
		logic [63:0] rdata;
	} mem_rsp_t;

	// Whole cache line, beat 0 in the low bits
	typedef logic [8*(2**OFFSET_BITS)-1:0] line_t;

endpackage

//--- source/dcache_request_router.sv
// Request router: IO start register, busy logic and data/IO request steering
`timescale 1ns/1ps

module dcache_request_router (
	input logic iCLOCK,
	input logic inRESET,
	input logic iosr_valid,
	input logic [31:0] iosr,
	input logic ldst_req,
	input dcache_pkg::ldst_req_t ldst,
	input logic ctrl_idle,
	input logic mem_lock,
	input logic io_busy,
	output logic ldst_busy,
	output logic accept_data,
	output logic accept_io,
	output dcache_pkg::ldst_req_t req_q,
	output logic io_req,
	output logic io_rw,
	output logic [31:0] io_addr,
	output logic [31:0] io_wdata
);

	logic io_start_valid;
	logic [31:0] io_start;
	logic take;
	logic in_io;

	// IO start address, loaded by the system strobe
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			io_start_valid <= 1'b0;
			io_start <= '0;
		end else if (iosr_valid) begin
			io_start_valid <= 1'b1;
			io_start <= iosr;
		end
	end

	// Pending accept_data also holds off the next request
	assign ldst_busy = !io_start_valid || accept_data || !ctrl_idle || mem_lock || io_busy;
	assign take = ldst_req && !ldst_busy;
	assign in_io = (ldst.addr >= io_start);

	// IO requests go straight out, rebased to the IO start
	assign accept_io = take && in_io;
	assign io_req = accept_io;
	assign io_rw = ldst.rw;
	assign io_addr = ldst.addr - io_start;
	assign io_wdata = ldst.wdata;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			accept_data <= 1'b0;
		end else begin
			accept_data <= take && !in_io;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (take && !in_io) begin
			req_q <= ldst;
		end
	end

endmodule

//--- source/dcache_line_store.sv
// Direct-mapped line store with tag, valid and data arrays
`timescale 1ns/1ps

module dcache_line_store (
	input logic iCLOCK,
	input logic inRESET,
	input logic lookup,
	input logic [31:0] lookup_addr,
	output logic hit,
	output logic [31:0] hit_word,
	input logic fill,
	input logic [31:0] fill_addr,
	input dcache_pkg::line_t fill_line,
	input logic update,
	input logic [31:0] update_addr,
	input logic [3:0] update_mask,
	input logic [31:0] update_data,
	input logic flush
);
	import dcache_pkg::*;

	logic [LINE_COUNT-1:0] valid_q;
	logic [TAG_BITS-1:0] tag_q [LINE_COUNT];
	line_t data_q [LINE_COUNT];

	logic [INDEX_BITS-1:0] lk_index;
	logic [INDEX_BITS-1:0] fill_index;
	logic [INDEX_BITS-1:0] upd_index;
	logic [TAG_BITS-1:0] lk_tag;
	logic [TAG_BITS-1:0] fill_tag;
	logic [TAG_BITS-1:0] upd_tag;
	logic [OFFSET_BITS-3:0] lk_word;
	logic [OFFSET_BITS-3:0] upd_word;
	logic upd_hit;

	// Address split: tag | index | word | byte
	assign lk_index = lookup_addr[OFFSET_BITS +: INDEX_BITS];
	assign lk_tag = lookup_addr[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
	assign lk_word = lookup_addr[OFFSET_BITS-1:2];
	assign fill_index = fill_addr[OFFSET_BITS +: INDEX_BITS];
	assign fill_tag = fill_addr[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
	assign upd_index = update_addr[OFFSET_BITS +: INDEX_BITS];
	assign upd_tag = update_addr[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
	assign upd_word = update_addr[OFFSET_BITS-1:2];

	// Write-through only touches a line already present
	assign upd_hit = update && valid_q[upd_index] && (tag_q[upd_index] == upd_tag);

	// Lookup result comes back one cycle later
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			hit <= 1'b0;
		end else if (lookup) begin
			hit <= valid_q[lk_index] && (tag_q[lk_index] == lk_tag);
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (lookup) begin
			hit_word <= data_q[lk_index][{lk_word, 5'b00000} +: 32];
		end
	end

	// Flush wins over a fill in the same cycle
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= '0;
		end else if (flush) begin
			valid_q <= '0;
		end else if (fill) begin
			valid_q[fill_index] <= 1'b1;
		end
	end

	// Tag and data arrays
	always_ff @(posedge iCLOCK) begin
		if (fill) begin
			tag_q[fill_index] <= fill_tag;
			data_q[fill_index] <= fill_line;
		end
		if (upd_hit) begin
			for (int b = 0; b < 4; b++) begin
				if (update_mask[b]) begin
					data_q[upd_index][{upd_word, 5'b00000} + b*8 +: 8] <= update_data[b*8 +: 8];
				end
			end
		end
	end

endmodule

//--- source/dcache_fill_controller.sv
// Cache path FSM: lookup, line fill with page-fault abort, and write-through
`timescale 1ns/1ps

module dcache_fill_controller (
	input logic iCLOCK,
	input logic inRESET,
	input logic accept_data,
	input dcache_pkg::ldst_req_t req_q,
	input logic hit,
	input logic [31:0] hit_word,
	output logic lookup,
	output logic [31:0] lookup_addr,
	output logic fill,
	output logic [31:0] fill_addr,
	output dcache_pkg::line_t fill_line,
	output logic update,
	output logic [31:0] update_addr,
	output logic [3:0] update_mask,
	output logic [31:0] update_data,
	output dcache_pkg::mem_req_t mem,
	input logic mem_lock,
	input dcache_pkg::mem_rsp_t mem_in,
	output logic idle,
	output dcache_pkg::ldst_rsp_t cache_rsp
);
	import dcache_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_FILL_REQ,
		ST_FILL_COLLECT,
		ST_WRITE_REQ,
		ST_WRITE_WAIT,
		ST_RESPOND
	} state_t;

	state_t state_q;
	logic [$clog2(BEATS_PER_LINE)-1:0] beat_q;
	line_t fill_line_q;
	logic [31:0] rsp_data_q;
	logic fault_q;
	logic last_beat;
	logic [31:0] beat_addr;

	// Beat n sits at line base + 8*n
	assign beat_addr = {req_q.addr[31:OFFSET_BITS], beat_q, 3'b000};
	assign last_beat = (beat_q == BEATS_PER_LINE - 1);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= ST_IDLE;
			beat_q <= '0;
			fault_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					beat_q <= '0;
					fault_q <= 1'b0;
					if (accept_data) begin
						state_q <= req_q.rw ? ST_LOOKUP : ST_WRITE_REQ;
					end
				end
				ST_LOOKUP: begin
					state_q <= hit ? ST_IDLE : ST_FILL_REQ;
				end
				ST_FILL_REQ: begin
					if (!mem_lock) begin
						state_q <= ST_FILL_COLLECT;
					end
				end
				ST_FILL_COLLECT: begin
					if (mem_in.valid) begin
						// A fault on any beat drops the whole line
						if (mem_in.pagefault) begin
							fault_q <= 1'b1;
							state_q <= ST_RESPOND;
						end else if (last_beat) begin
							state_q <= ST_RESPOND;
						end else begin
							beat_q <= beat_q + 1'b1;
							state_q <= ST_FILL_REQ;
						end
					end
				end
				ST_WRITE_REQ: begin
					if (!mem_lock) begin
						state_q <= ST_WRITE_WAIT;
					end
				end
				ST_WRITE_WAIT: begin
					if (mem_in.valid) begin
						fault_q <= mem_in.pagefault;
						state_q <= ST_RESPOND;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// Beats shift in from the top, so beat 0 ends up lowest
	always_ff @(posedge iCLOCK) begin
		if (state_q == ST_FILL_COLLECT && mem_in.valid) begin
			fill_line_q <= {mem_in.rdata, fill_line_q[$bits(line_t)-1:64]};
			if (beat_q == req_q.addr[5:3]) begin
				rsp_data_q <= req_q.addr[2] ? mem_in.rdata[63:32] : mem_in.rdata[31:0];
			end
		end
	end

	// Line store side
	assign lookup = (state_q == ST_IDLE) && accept_data && req_q.rw;
	assign lookup_addr = req_q.addr;
	assign fill = (state_q == ST_RESPOND) && req_q.rw && !fault_q;
	assign fill_addr = req_q.addr;
	assign fill_line = fill_line_q;
	assign update = (state_q == ST_WRITE_REQ) && !mem_lock;
	assign update_addr = req_q.addr;
	assign update_mask = req_q.mask;
	assign update_data = req_q.wdata;

	// Memory bus, fields held steady while locked
	always_comb begin
		mem.req = (state_q == ST_FILL_REQ) || (state_q == ST_WRITE_REQ);
		mem.rw = (state_q == ST_FILL_REQ);
		mem.mask = (state_q == ST_FILL_REQ) ? 4'hf : req_q.mask;
		mem.addr = (state_q == ST_FILL_REQ) ? beat_addr : req_q.addr;
		mem.wdata = req_q.wdata;
	end

	assign idle = (state_q == ST_IDLE);

	// Hit answers straight from the store, misses and writes from RESPOND
	always_comb begin
		cache_rsp = '0;
		if (state_q == ST_LOOKUP && hit) begin
			cache_rsp.valid = 1'b1;
			cache_rsp.data = hit_word;
		end else if (state_q == ST_RESPOND) begin
			cache_rsp.valid = 1'b1;
			cache_rsp.pagefault = fault_q;
			cache_rsp.data = (req_q.rw && !fault_q) ? rsp_data_q : '0;
		end
	end

endmodule

//--- source/dcache_response_merge.sv
// Response merge: registers the cache path or IO port answer to the load/store unit
`timescale 1ns/1ps

module dcache_response_merge (
	input logic iCLOCK,
	input logic inRESET,
	input logic accept_io,
	input dcache_pkg::ldst_rsp_t cache_rsp,
	input logic io_valid,
	input logic [31:0] io_rdata,
	output dcache_pkg::ldst_rsp_t ldst_rsp
);

	logic io_pending;

	// One IO request outstanding at a time
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			io_pending <= 1'b0;
		end else if (accept_io) begin
			io_pending <= 1'b1;
		end else if (io_valid) begin
			io_pending <= 1'b0;
		end
	end

	// IO first, then the cache path
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ldst_rsp <= '0;
		end else if (io_valid && io_pending) begin
			ldst_rsp.valid <= 1'b1;
			ldst_rsp.pagefault <= 1'b0;
			ldst_rsp.data <= io_rdata;
		end else if (cache_rsp.valid) begin
			ldst_rsp <= cache_rsp;
		end else begin
			ldst_rsp.valid <= 1'b0;
		end
	end

endmodule

//--- source/dcache_top.sv
// L1 data cache top level: router, fill controller, line store and response merge
`timescale 1ns/1ps

module dcache_top (
	input logic iCLOCK,
	input logic inRESET,
	input logic iosr_valid,
	input logic [31:0] iosr,
	input logic cache_flush,
	input logic ldst_req,
	input dcache_pkg::ldst_req_t ldst,
	output logic ldst_busy,
	output dcache_pkg::ldst_rsp_t ldst_rsp,
	output dcache_pkg::mem_req_t mem,
	input logic mem_lock,
	input dcache_pkg::mem_rsp_t mem_in,
	output logic io_req,
	output logic io_rw,
	output logic [31:0] io_addr,
	output logic [31:0] io_wdata,
	input logic io_busy,
	input logic io_valid,
	input logic [31:0] io_rdata
);
	import dcache_pkg::*;

	logic accept_data;
	logic accept_io;
	ldst_req_t req_q;
	logic ctrl_idle;
	ldst_rsp_t cache_rsp;

	// Controller to line store
	logic lookup;
	logic [31:0] lookup_addr;
	logic hit;
	logic [31:0] hit_word;
	logic fill;
	logic [31:0] fill_addr;
	line_t fill_line;
	logic update;
	logic [31:0] update_addr;
	logic [3:0] update_mask;
	logic [31:0] update_data;

	dcache_request_router u_router (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.iosr_valid(iosr_valid), .iosr(iosr),
		.ldst_req(ldst_req), .ldst(ldst),
		.ctrl_idle(ctrl_idle), .mem_lock(mem_lock), .io_busy(io_busy),
		.ldst_busy(ldst_busy), .accept_data(accept_data), .accept_io(accept_io),
		.req_q(req_q), .io_req(io_req), .io_rw(io_rw),
		.io_addr(io_addr), .io_wdata(io_wdata)
	);

	dcache_fill_controller u_ctrl (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.accept_data(accept_data), .req_q(req_q),
		.hit(hit), .hit_word(hit_word),
		.lookup(lookup), .lookup_addr(lookup_addr),
		.fill(fill), .fill_addr(fill_addr), .fill_line(fill_line),
		.update(update), .update_addr(update_addr),
		.update_mask(update_mask), .update_data(update_data),
		.mem(mem), .mem_lock(mem_lock), .mem_in(mem_in),
		.idle(ctrl_idle), .cache_rsp(cache_rsp)
	);

	dcache_line_store u_store (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.lookup(lookup), .lookup_addr(lookup_addr),
		.hit(hit), .hit_word(hit_word),
		.fill(fill), .fill_addr(fill_addr), .fill_line(fill_line),
		.update(update), .update_addr(update_addr),
		.update_mask(update_mask), .update_data(update_data),
		.flush(cache_flush)
	);

	dcache_response_merge u_merge (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.accept_io(accept_io), .cache_rsp(cache_rsp),
		.io_valid(io_valid), .io_rdata(io_rdata),
		.ldst_rsp(ldst_rsp)
	);

endmodule

//--- tests/dcache_sva.sv
// Protocol assertions on the dcache_top ports and their bind
`timescale 1ns/1ps

module dcache_sva (
	input logic iCLOCK,
	input logic inRESET,
	input logic iosr_valid,
	input logic ldst_busy,
	input dcache_pkg::ldst_rsp_t ldst_rsp,
	input dcache_pkg::mem_req_t mem,
	input logic mem_lock,
	input logic io_req
);

	logic strobed;
	int pulse_fails = 0;
	int stable_fails = 0;
	int overlap_fails = 0;
	int busy_fails = 0;
	int fail_count;

	assign fail_count = pulse_fails + stable_fails + overlap_fails + busy_fails;

	// Set by the first IO start strobe
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			strobed <= 1'b0;
		end else if (iosr_valid) begin
			strobed <= 1'b1;
		end
	end

	rsp_single_pulse: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ldst_rsp.valid |=> !ldst_rsp.valid)
	else begin
		$error("ldst_rsp.valid high two cycles in a row");
		pulse_fails++;
	end

	// Locked request keeps every field
	mem_held: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(mem.req && mem_lock) |=> $stable(mem))
	else begin
		$error("memory request changed while locked");
		stable_fails++;
	end

	io_mem_exclusive: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(io_req && mem.req))
	else begin
		$error("io_req and mem.req high together");
		overlap_fails++;
	end

	busy_until_strobe: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!strobed |-> ldst_busy)
	else begin
		$error("ldst_busy low before the IO start strobe");
		busy_fails++;
	end

endmodule

bind dcache_top dcache_sva u_sva (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.iosr_valid(iosr_valid),
	.ldst_busy(ldst_busy),
	.ldst_rsp(ldst_rsp),
	.mem(mem),
	.mem_lock(mem_lock),
	.io_req(io_req)
);

//--- tests/dcache_tb.sv
// Directed testbench for dcache_top with memory and IO models, compare tasks and a watchdog
`timescale 1ns/1ps

module dcache_tb;
	import dcache_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 3;
	localparam int TEST_COUNT = 6;
	localparam int CYCLES_PER_TEST = 2000;
	localparam int ACCEPT_LIMIT = 200;
	localparam int RSP_LIMIT = 400;
	localparam logic [31:0] IO_START = 32'h8000_0000;
	localparam logic [19:0] FAULT_PAGE = 20'h00003;

	logic iCLOCK = 1'b0;
	logic inRESET;
	logic iosr_valid;
	logic [31:0] iosr;
	logic cache_flush;
	logic ldst_req;
	ldst_req_t ldst;
	logic ldst_busy;
	ldst_rsp_t ldst_rsp;
	mem_req_t mem;
	logic mem_lock = 1'b0;
	mem_rsp_t mem_in = '0;
	logic io_req;
	logic io_rw;
	logic [31:0] io_addr;
	logic [31:0] io_wdata;
	logic io_busy = 1'b0;
	logic io_valid = 1'b0;
	logic [31:0] io_rdata = '0;

	// Memory model state
	logic [31:0] mem_data [logic [31:0]];
	integer seed = 32'h6d59fded;
	logic lock_enable = 1'b0;
	logic pend_busy = 1'b0;
	int pend_wait = 0;
	mem_req_t pend_req;
	int read_beats = 0;
	int mem_reqs = 0;

	// IO model state
	int io_reqs = 0;
	int io_handled = 0;
	int io_wait = 0;
	logic [31:0] io_addr_seen;
	logic io_rw_seen;
	logic [31:0] io_wdata_seen;

	string cur_test;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;

	dcache_top u_dut (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.iosr_valid(iosr_valid), .iosr(iosr), .cache_flush(cache_flush),
		.ldst_req(ldst_req), .ldst(ldst), .ldst_busy(ldst_busy), .ldst_rsp(ldst_rsp),
		.mem(mem), .mem_lock(mem_lock), .mem_in(mem_in),
		.io_req(io_req), .io_rw(io_rw), .io_addr(io_addr), .io_wdata(io_wdata),
		.io_busy(io_busy), .io_valid(io_valid), .io_rdata(io_rdata)
	);

	always #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;

	// Untouched memory reads back its own address XOR a fixed pattern
	function automatic logic [31:0] pattern_word(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
	endfunction

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] key;
		key = {addr[31:2], 2'b00};
		if (mem_data.exists(key)) begin
			return mem_data[key];
		end
		return pattern_word(key);
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] mask);
		logic [31:0] r;
		r = old_w;
		for (int b = 0; b < 4; b++) begin
			if (mask[b]) begin
				r[b*8 +: 8] = new_w[b*8 +: 8];
			end
		end
		return r;
	endfunction

	// Requests are taken on a falling edge with mem_lock low and answered 1 to 3 cycles later
	always @(negedge iCLOCK) begin
		mem_in = '0;
		if (pend_busy) begin
			if (pend_wait == 0) begin
				pend_busy = 1'b0;
				mem_in.valid = 1'b1;
				mem_in.pagefault = (pend_req.addr[31:12] == FAULT_PAGE);
				if (pend_req.rw) begin
					read_beats++;
					mem_in.rdata = {mem_word(pend_req.addr + 32'd4), mem_word(pend_req.addr)};
				end else if (!mem_in.pagefault) begin
					mem_data[{pend_req.addr[31:2], 2'b00}] =
						merge_bytes(mem_word(pend_req.addr), pend_req.wdata, pend_req.mask);
				end
			end else begin
				pend_wait--;
			end
		end
		mem_lock = lock_enable && (($unsigned($random(seed)) % 4) == 0);
		if (mem.req && !mem_lock && !pend_busy) begin
			pend_busy = 1'b1;
			pend_wait = $unsigned($random(seed)) % 3;
			pend_req = mem;
			mem_reqs++;
		end
	end

	always @(posedge iCLOCK) begin
		if (io_req) begin
			io_reqs++;
			io_addr_seen = io_addr;
			io_rw_seen = io_rw;
			io_wdata_seen = io_wdata;
		end
	end

	// IO answers two cycles after io_req
	always @(negedge iCLOCK) begin
		io_valid = 1'b0;
		if (io_wait > 0) begin
			io_wait--;
			if (io_wait == 0) begin
				io_valid = 1'b1;
				io_rdata = 32'h1000_0000 + io_addr_seen;
				io_busy = 1'b0;
			end
		end
		if (io_reqs != io_handled) begin
			io_handled = io_reqs;
			io_wait = 1;
			io_busy = 1'b1;
		end
	end

	task automatic check_rsp(input string what, input ldst_rsp_t expected,
			input ldst_rsp_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s %s: expected v=%b pf=%b data=%h, actual v=%b pf=%b data=%h",
				cur_test, what, expected.valid, expected.pagefault, expected.data,
				actual.valid, actual.pagefault, actual.data);
		end
	endtask

	task automatic check_count(input string what, input integer expected, input integer actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s %s: expected %0d, actual %0d",
				cur_test, what, expected, actual);
		end
	endtask

	task automatic check_word(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, expected, actual);
		end
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, expected, actual);
		end
	endtask

	function automatic ldst_req_t read_req(input logic [31:0] addr);
		ldst_req_t r;
		r.rw = 1'b1;
		r.mask = 4'hf;
		r.addr = addr;
		r.wdata = '0;
		return r;
	endfunction

	function automatic ldst_req_t write_req(input logic [31:0] addr, input logic [3:0] mask,
			input logic [31:0] data);
		ldst_req_t r;
		r.rw = 1'b0;
		r.mask = mask;
		r.addr = addr;
		r.wdata = data;
		return r;
	endfunction

	function automatic ldst_rsp_t make_rsp(input logic fault, input logic [31:0] data);
		ldst_rsp_t r;
		r.valid = 1'b1;
		r.pagefault = fault;
		r.data = data;
		return r;
	endfunction

	// Holds the request until accepted and then waits for the response pulse
	task automatic do_access(input ldst_req_t req, output ldst_rsp_t rsp, output int latency);
		int wait_n;
		logic accepted;
		wait_n = 0;
		accepted = 1'b0;
		latency = 0;
		rsp = '0;
		@(negedge iCLOCK);
		ldst = req;
		ldst_req = 1'b1;
		while (!accepted && wait_n < ACCEPT_LIMIT) begin
			@(posedge iCLOCK);
			if (!ldst_busy) begin
				accepted = 1'b1;
			end else begin
				wait_n++;
			end
		end
		@(negedge iCLOCK);
		ldst_req = 1'b0;
		if (!accepted) begin
			errors++;
			$display("%s: request at %h was never accepted", cur_test, req.addr);
			return;
		end
		while (!ldst_rsp.valid && latency < RSP_LIMIT) begin
			@(negedge iCLOCK);
			latency++;
		end
		if (!ldst_rsp.valid) begin
			errors++;
			$display("%s: no response for the request at %h", cur_test, req.addr);
		end
		rsp = ldst_rsp;
	endtask

	task automatic report_test(input int first_err);
		tests_run++;
		$display("Test %s finished with %0d errors", cur_test, errors - first_err);
	endtask

	task automatic reset_and_io_start();
		int first_err;
		first_err = errors;
		cur_test = "reset_io_start";
		repeat (4) begin
			@(negedge iCLOCK);
			check_flag("busy before strobe", 1'b1, ldst_busy);
		end
		check_flag("response valid after reset", 1'b0, ldst_rsp.valid);
		check_flag("memory request after reset", 1'b0, mem.req);
		check_flag("io request after reset", 1'b0, io_req);
		iosr = IO_START;
		iosr_valid = 1'b1;
		@(negedge iCLOCK);
		iosr_valid = 1'b0;
		check_flag("busy after strobe", 1'b0, ldst_busy);
		report_test(first_err);
	endtask

	task automatic miss_then_hit();
		int first_err;
		int beats0;
		int lat;
		ldst_rsp_t rsp;
		first_err = errors;
		cur_test = "miss_then_hit";
		beats0 = read_beats;
		do_access(read_req(32'h0000_1048), rsp, lat);
		check_rsp("miss data", make_rsp(1'b0, pattern_word(32'h0000_1048)), rsp);
		check_count("miss beats", 8, read_beats - beats0);
		beats0 = read_beats;
		do_access(read_req(32'h0000_1074), rsp, lat);
		check_rsp("hit data", make_rsp(1'b0, pattern_word(32'h0000_1074)), rsp);
		check_count("hit beats", 0, read_beats - beats0);
		check_count("hit latency", 2, lat);
		report_test(first_err);
	endtask

	task automatic write_through();
		int first_err;
		int beats0;
		int lat;
		logic [31:0] merged;
		ldst_rsp_t rsp;
		first_err = errors;
		cur_test = "write_through";
		merged = merge_bytes(pattern_word(32'h0000_1048), 32'h1122_3344, 4'b0101);
		do_access(write_req(32'h0000_1048, 4'b0101, 32'h1122_3344), rsp, lat);
		check_rsp("write ack", make_rsp(1'b0, 32'h0), rsp);
		check_word("memory word", merged, mem_word(32'h0000_1048));
		beats0 = read_beats;
		do_access(read_req(32'h0000_1048), rsp, lat);
		check_rsp("merged read", make_rsp(1'b0, merged), rsp);
		check_count("merged read beats", 0, read_beats - beats0);
		// Uncached line stays uncached
		do_access(write_req(32'h0000_2000, 4'hf, 32'hDEAD_BEEF), rsp, lat);
		check_rsp("uncached write ack", make_rsp(1'b0, 32'h0), rsp);
		beats0 = read_beats;
		do_access(read_req(32'h0000_2000), rsp, lat);
		check_rsp("uncached read", make_rsp(1'b0, 32'hDEAD_BEEF), rsp);
		check_count("uncached read beats", 8, read_beats - beats0);
		report_test(first_err);
	endtask

	task automatic io_routing();
		int first_err;
		int reqs0;
		int lat;
		ldst_rsp_t rsp;
		first_err = errors;
		cur_test = "io_routing";
		reqs0 = mem_reqs;
		do_access(read_req(IO_START + 32'd12), rsp, lat);
		check_word("io read address", 32'd12, io_addr_seen);
		check_flag("io read rw", 1'b1, io_rw_seen);
		check_rsp("io read data", make_rsp(1'b0, 32'h1000_000C), rsp);
		do_access(write_req(IO_START + 32'h20, 4'hf, 32'hCAFE_0001), rsp, lat);
		check_word("io write address", 32'h20, io_addr_seen);
		check_flag("io write rw", 1'b0, io_rw_seen);
		check_word("io write data", 32'hCAFE_0001, io_wdata_seen);
		check_rsp("io write ack", make_rsp(1'b0, 32'h1000_0020), rsp);
		check_count("memory requests", 0, mem_reqs - reqs0);
		report_test(first_err);
	endtask

	task automatic page_fault_abort();
		int first_err;
		int beats0;
		int lat;
		ldst_rsp_t rsp;
		first_err = errors;
		cur_test = "page_fault";
		repeat (2) begin
			beats0 = read_beats;
			do_access(read_req(32'h0000_3010), rsp, lat);
			check_rsp("fault response", make_rsp(1'b1, 32'h0), rsp);
			check_count("fault beats", 1, read_beats - beats0);
		end
		report_test(first_err);
	endtask

	task automatic flush_lines();
		int first_err;
		int beats0;
		int lat;
		ldst_rsp_t rsp;
		first_err = errors;
		cur_test = "flush";
		beats0 = read_beats;
		do_access(read_req(32'h0000_1074), rsp, lat);
		check_rsp("data before flush", make_rsp(1'b0, pattern_word(32'h0000_1074)), rsp);
		check_count("beats before flush", 0, read_beats - beats0);
		@(negedge iCLOCK);
		cache_flush = 1'b1;
		@(negedge iCLOCK);
		cache_flush = 1'b0;
		beats0 = read_beats;
		do_access(read_req(32'h0000_1074), rsp, lat);
		check_rsp("refill data", make_rsp(1'b0, pattern_word(32'h0000_1074)), rsp);
		check_count("beats after flush", 8, read_beats - beats0);
		report_test(first_err);
	endtask

	initial begin
		#(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
		$display("Watchdog: the run did not finish in time");
		$display("Done: errors found");
		$finish;
	end

	initial begin
		inRESET = 1'b0;
		iosr_valid = 1'b0;
		iosr = '0;
		cache_flush = 1'b0;
		ldst_req = 1'b0;
		ldst = '0;
		repeat (RESET_CYCLES) @(negedge iCLOCK);
		inRESET = 1'b1;
		reset_and_io_start();
		lock_enable = 1'b1;
		miss_then_hit();
		write_through();
		io_routing();
		page_fault_abort();
		flush_lines();
		repeat (4) @(negedge iCLOCK);
		errors += u_dut.u_sva.fail_count;
		$display("Summary: %0d tests, %0d checks, %0d assertion failures, %0d errors",
			tests_run, checks, u_dut.u_sva.fail_count, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- dcache_top.f
source/dcache_pkg.sv
source/dcache_request_router.sv
source/dcache_line_store.sv
source/dcache_fill_controller.sv
source/dcache_response_merge.sv
source/dcache_top.sv
tests/dcache_sva.sv
tests/dcache_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --timing --assert
TOP      = dcache_tb
FILELIST = dcache_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+100
PASS_MSG = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
